/* design/retire_isa_pkg.sv */
package retire_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Execution unit classes
    ////////////////////////////////////////////////////////////////////////////

    // Upper three bits of every operation code select one of these
    typedef enum logic [2:0] {
        ALU_UNIT    = 3'b000,
        BRANCH_UNIT = 3'b001,
        MEMORY_UNIT = 3'b010,
        SYSTEM_UNIT = 3'b011
    } exec_unit_e;

    ////////////////////////////////////////////////////////////////////////////
    // Operation codes seen by retire
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // ALU unit
        NOP    = 6'b000_000,
        ADD    = 6'b000_001,
        // Branch unit
        BRANCH = 6'b001_000,
        // Memory unit, loads first and stores after
        LB     = 6'b010_000,
        LBU    = 6'b010_001,
        LH     = 6'b010_010,
        LHU    = 6'b010_011,
        LW     = 6'b010_100,
        SB     = 6'b010_101,
        SH     = 6'b010_110,
        SW     = 6'b010_111,
        // System unit
        ECALL  = 6'b011_000,
        EBREAK = 6'b011_001,
        MRET   = 6'b011_010
    } instr_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Trap causes, numbered as in mcause
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        NE                  = 4'd0,   // No exception
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } exc_code_e;

    // Unit class of an operation, taken from its top bits
    function automatic exec_unit_e unit_of(input instr_op_e op);
        return exec_unit_e'(op[5:3]);
    endfunction

endpackage

/* design/retire_bus_pkg.sv */
package retire_bus_pkg;

    import retire_isa_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction handed over by execute
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;        // One-cycle strobe, no back-pressure
        logic [31:0] instruction;  // Raw encoding
        logic [31:0] pc;           // Also the fall-through target on a bad prediction
        logic [31:0] result;       // ALU result or store data
        logic [31:0] addr_target;  // Memory address or branch target
        instr_op_e   op;
        logic        reg_write;    // Execute wants a register write
        logic        illegal;      // Decode flagged the encoding
        logic [3:0]  byte_enable;  // Nonzero for stores
        logic        jump_taken;   // Branch unit outcome
        logic        predicted;    // Fetch already followed the branch
    } retire_in_t;

    ////////////////////////////////////////////////////////////////////////////
    // Retire effects
    ////////////////////////////////////////////////////////////////////////////

    // Register bank write port
    typedef struct packed {
        logic        enable;
        logic [31:0] data;
    } regbank_wb_t;

    // Store request to data memory
    typedef struct packed {
        logic [3:0]  byte_enable;  // All zero means no store
        logic [31:0] address;
        logic [31:0] data;
    } mem_write_t;

    // Fetch redirect
    typedef struct packed {
        logic        jump;
        logic [31:0] target;
    } redirect_t;

    // Privileged events for the CSR side
    typedef struct packed {
        logic      raise_exception;
        exc_code_e code;
        logic      machine_return;
        logic      interrupt_ack;
    } trap_t;

endpackage

/* design/load_align.sv */
`timescale 1ns/1ps

module load_align
    import retire_isa_pkg::*;
(
    input  instr_op_e   op_i,         // Operation of the retiring instruction
    input  logic [1:0]  addr_lo_i,    // Byte offset inside the word
    input  logic [31:0] mem_data_i,   // Full word returned by memory
    output logic [31:0] load_data_o   // Aligned and extended value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    ////////////////////////////////////////////////////////////////////////////
    // Lane selection
    ////////////////////////////////////////////////////////////////////////////

    // Little endian, offset 0 is the low byte
    always_comb begin
        case (addr_lo_i)
            2'b11:   byte_sel = mem_data_i[31:24];
            2'b10:   byte_sel = mem_data_i[23:16];
            2'b01:   byte_sel = mem_data_i[15:8];
            default: byte_sel = mem_data_i[7:0];
        endcase
    end

    // Halfword picked by bit 1 only, bit 0 is assumed aligned
    assign half_sel = addr_lo_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

    ////////////////////////////////////////////////////////////////////////////
    // Extension
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            LB: begin
                load_data_o = {{24{byte_sel[7]}}, byte_sel};   // Sign from bit 7
            end
            LBU: begin
                load_data_o = {24'h000000, byte_sel};
            end
            LH: begin
                load_data_o = {{16{half_sel[15]}}, half_sel};  // Sign from bit 15
            end
            LHU: begin
                load_data_o = {16'h0000, half_sel};
            end
            default: begin
                // LW and everything else see the raw word
                load_data_o = mem_data_i;
            end
        endcase
    end

endmodule

/* design/trap_decode.sv */
`timescale 1ns/1ps

module trap_decode
    import retire_isa_pkg::*;
    import retire_bus_pkg::*;
(
    input  instr_op_e op_i,           // Operation of the retiring instruction
    input  logic      illegal_i,      // Decode marked it illegal
    input  logic      irq_pending_i,  // Interrupt controller has something waiting
    output trap_t     trap_o          // Not yet gated by the kill
);

    ////////////////////////////////////////////////////////////////////////////
    // Priority chain
    ////////////////////////////////////////////////////////////////////////////

    // Synchronous exceptions of the instruction itself come first,
    // the interrupt is only taken on an instruction that traps on nothing
    always_comb begin
        // Quiet default
        trap_o.raise_exception = 1'b0;
        trap_o.code            = NE;
        trap_o.machine_return  = 1'b0;
        trap_o.interrupt_ack   = 1'b0;

        if (illegal_i) begin
            // Wins over whatever op decode produced
            trap_o.raise_exception = 1'b1;
            trap_o.code            = ILLEGAL_INSTRUCTION;
        end
        else if (op_i == ECALL) begin
            trap_o.raise_exception = 1'b1;
            trap_o.code            = ECALL_FROM_MMODE;   // Only M-mode in this core
        end
        else if (op_i == EBREAK) begin
            trap_o.raise_exception = 1'b1;
            trap_o.code            = BREAKPOINT;
        end
        else if (op_i == MRET) begin
            trap_o.machine_return  = 1'b1;               // No cause code for a return
        end
        else if (irq_pending_i) begin
            trap_o.interrupt_ack   = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // CSR side handles one privileged event per instruction
    always_comb begin
        assert final ($onehot0({trap_o.raise_exception,
                                trap_o.machine_return,
                                trap_o.interrupt_ack}))
        else $error("trap_decode: more than one privileged event at once");
    end

endmodule

/* design/retire_ctrl.sv */
`timescale 1ns/1ps

module retire_ctrl
    import retire_isa_pkg::*;
    import retire_bus_pkg::*;
#(
    parameter int TAG_WIDTH = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  retire_in_t           ret_i,        // Instruction from execute
    input  logic [TAG_WIDTH-1:0] tag_i,        // Tag the instruction was issued under
    input  logic [31:0]          load_data_i,  // From load_align
    input  trap_t                trap_raw_i,   // From trap_decode, not yet gated
    output regbank_wb_t          wb_o,
    output mem_write_t           mem_o,
    output redirect_t            redirect_o,
    output trap_t                trap_o,
    output logic                 killed_o,     // Valid but issued under a stale tag
    output logic [TAG_WIDTH-1:0] tag_o         // Current retire tag
);

    logic [TAG_WIDTH-1:0] tag_q;
    logic                 live;      // Valid and on the current path
    logic                 advance;   // Path changes so the tag steps

    ////////////////////////////////////////////////////////////////////////////
    // Tag and kill
    ////////////////////////////////////////////////////////////////////////////

    assign tag_o    = tag_q;
    assign live     = ret_i.valid && (tag_i == tag_q);
    assign killed_o = ret_i.valid && (tag_i != tag_q);

    // Every change of control flow opens a new path
    assign advance = redirect_o.jump | trap_o.raise_exception
                   | trap_o.machine_return | trap_o.interrupt_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_q <= '0;
        end
        else if (advance) begin
            tag_q <= tag_q + 1'b1;   // Wraps at TAG_WIDTH
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback and store
    ////////////////////////////////////////////////////////////////////////////

    assign wb_o.enable = live && ret_i.reg_write;
    assign wb_o.data   = (unit_of(ret_i.op) == MEMORY_UNIT) ? load_data_i : ret_i.result;

    always_comb begin
        mem_o = '0;
        if (live && ret_i.byte_enable != 4'b0000) begin
            mem_o.byte_enable = ret_i.byte_enable;
            mem_o.address     = ret_i.addr_target;
            mem_o.data        = ret_i.result;      // Store data rides on result
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Redirect and trap gating
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        redirect_o = '0;
        if (live && ret_i.jump_taken && !ret_i.predicted) begin
            redirect_o.jump   = 1'b1;              // Missed a taken branch
            redirect_o.target = ret_i.addr_target;
        end
        else if (live && !ret_i.jump_taken && ret_i.predicted) begin
            redirect_o.jump   = 1'b1;              // Followed a branch that falls through
            redirect_o.target = ret_i.pc;
        end
    end

    assign trap_o = live ? trap_raw_i : '0;        // All-zero is NE with no events

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Stale instructions leave no trace anywhere
    a_killed_silent: assert property (@(posedge clk) disable iff (reset)
        killed_o |-> !(wb_o.enable || mem_o.byte_enable != 4'b0000 || advance))
    else $error("retire_ctrl: killed instruction produced an effect");

    a_tag_hold: assert property (@(posedge clk) disable iff (reset)
        !advance |=> $stable(tag_o))
    else $error("retire_ctrl: tag moved without redirect or trap");

endmodule

/* design/retire_top.sv */
`timescale 1ns/1ps

module retire_top
    import retire_bus_pkg::*;
#(
    parameter int TAG_WIDTH = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    // Execute stage
    input  retire_in_t           ret_i,
    input  logic [TAG_WIDTH-1:0] tag_i,
    // Data memory read, combinational for ret_i.addr_target
    input  logic [31:0]          mem_data_i,
    // Interrupt controller
    input  logic                 irq_pending_i,
    // Retire effects
    output regbank_wb_t          wb_o,
    output mem_write_t           mem_o,
    output redirect_t            redirect_o,
    output trap_t                trap_o,
    output logic                 killed_o,
    output logic [TAG_WIDTH-1:0] tag_o
);

    logic [31:0] load_data;   // Aligned load value
    trap_t       trap_raw;    // Trap decision before kill gating

    ////////////////////////////////////////////////////////////////////////////
    // Decoders
    ////////////////////////////////////////////////////////////////////////////

    load_align load_align_i (
        .op_i        (ret_i.op),
        .addr_lo_i   (ret_i.addr_target[1:0]),
        .mem_data_i  (mem_data_i),
        .load_data_o (load_data)
    );

    trap_decode trap_decode_i (
        .op_i          (ret_i.op),
        .illegal_i     (ret_i.illegal),
        .irq_pending_i (irq_pending_i),
        .trap_o        (trap_raw)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Controller
    ////////////////////////////////////////////////////////////////////////////

    retire_ctrl #(
        .TAG_WIDTH (TAG_WIDTH)
    ) retire_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .ret_i       (ret_i),
        .tag_i       (tag_i),
        .load_data_i (load_data),
        .trap_raw_i  (trap_raw),
        .wb_o        (wb_o),
        .mem_o       (mem_o),
        .redirect_o  (redirect_o),
        .trap_o      (trap_o),
        .killed_o    (killed_o),
        .tag_o       (tag_o)
    );

endmodule

/* testbench/retire_model.svh */
`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

logic [31:0] lcg_state = 32'h060c_7f95;

// Numerical Recipes constants, full 32-bit period
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Small draws use the upper half, low LCG bits repeat quickly
function automatic logic [31:0] rand_below(input logic [31:0] n);
    logic [31:0] r;
    r = lcg_next();
    return {16'h0000, r[31:16]} % n;
endfunction

function automatic instr_op_e pick_op();
    case (rand_below(16))
        0:       return NOP;
        1:       return ADD;
        2:       return LB;
        3:       return LBU;
        4:       return LH;
        5:       return LHU;
        6:       return LW;
        7:       return SB;
        8:       return SH;
        9:       return SW;
        10:      return ECALL;
        11:      return EBREAK;
        12:      return MRET;
        default: return BRANCH;   // Branches weighted up to cover all four cases
    endcase
endfunction

function automatic logic is_load(input instr_op_e op);
    return op inside {LB, LBU, LH, LHU, LW};
endfunction

function automatic logic is_memory_op(input instr_op_e op);
    return is_load(op) || op inside {SB, SH, SW};   // Stores still read the word back
endfunction

// One instruction as execute would present it
function automatic retire_in_t random_instr();
    retire_in_t r;
    r             = '0;
    r.valid       = rand_below(10) != 0;               // Roughly one bubble in ten
    r.instruction = lcg_next();
    r.pc          = lcg_next() & 32'hffff_fffc;
    r.result      = lcg_next();
    r.addr_target = lcg_next();
    r.op          = pick_op();
    r.illegal     = rand_below(16) == 0;
    // ALU and loads mostly write, the rest only now and then
    if (r.op inside {NOP, ADD} || is_load(r.op)) begin
        r.reg_write = rand_below(8) != 0;
    end
    else begin
        r.reg_write = rand_below(8) == 0;
    end
    // Store lanes follow width and offset, sometimes none at all
    if (r.op inside {SB, SH, SW} && rand_below(8) != 0) begin
        case (r.op)
            SB:      r.byte_enable = 4'b0001 << r.addr_target[1:0];
            SH:      r.byte_enable = r.addr_target[1] ? 4'b1100 : 4'b0011;
            default: r.byte_enable = 4'b1111;
        endcase
    end
    if (r.op == BRANCH) begin
        r.jump_taken = lcg_next() >= 32'h8000_0000;
        r.predicted  = lcg_next() >= 32'h8000_0000;
    end
    return r;
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected effects
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] aligned_load(input instr_op_e op, input logic [1:0] off,
                                             input logic [31:0] word);
    logic [31:0] by_byte;
    logic [31:0] by_half;
    by_byte = word >> {off, 3'b000};         // Wanted byte moved to bits 7:0
    by_half = word >> {off[1], 4'b0000};     // Wanted halfword moved to bits 15:0
    case (op)
        LB:      return {{24{by_byte[7]}}, by_byte[7:0]};
        LBU:     return {24'h000000, by_byte[7:0]};
        LH:      return {{16{by_half[15]}}, by_half[15:0]};
        LHU:     return {16'h0000, by_half[15:0]};
        default: return word;
    endcase
endfunction

function automatic regbank_wb_t wb_expect(input retire_in_t r, input logic live,
                                          input logic [31:0] word);
    regbank_wb_t w;
    w        = '0;
    w.enable = live && r.reg_write;
    if (is_memory_op(r.op)) w.data = aligned_load(r.op, r.addr_target[1:0], word);
    else                    w.data = r.result;
    return w;
endfunction

function automatic mem_write_t store_expect(input retire_in_t r, input logic live);
    mem_write_t m;
    m = '0;
    if (live && r.byte_enable != 4'b0000) begin
        m.byte_enable = r.byte_enable;
        m.address     = r.addr_target;
        m.data        = r.result;
    end
    return m;
endfunction

// Redirect only when the prediction and the outcome disagree
function automatic redirect_t redirect_expect(input retire_in_t r, input logic live);
    redirect_t d;
    d = '0;
    if (live && r.jump_taken != r.predicted) begin
        d.jump   = 1'b1;
        d.target = r.jump_taken ? r.addr_target : r.pc;
    end
    return d;
endfunction

function automatic trap_t trap_expect(input retire_in_t r, input logic live, input logic irq);
    trap_t t;
    t      = '0;
    t.code = NE;
    if (!live) return t;
    if (r.illegal) begin
        t.raise_exception = 1'b1;
        t.code            = ILLEGAL_INSTRUCTION;
    end
    else if (r.op == ECALL) begin
        t.raise_exception = 1'b1;
        t.code            = ECALL_FROM_MMODE;
    end
    else if (r.op == EBREAK) begin
        t.raise_exception = 1'b1;
        t.code            = BREAKPOINT;
    end
    else if (r.op == MRET) t.machine_return = 1'b1;
    else if (irq)          t.interrupt_ack  = 1'b1;   // Lowest priority
    return t;
endfunction

`endif

/* testbench/retire_tb.sv */
`timescale 1ns/1ps

module retire_tb
    import retire_isa_pkg::*;
    import retire_bus_pkg::*;
();

    localparam int TAG_WIDTH      = 3;
    localparam int NUM_INSTR      = 2000;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 100;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    logic        clk;
    logic        reset;
    retire_in_t  ret_in;
    tag_t        tag_in;
    logic [31:0] mem_data;     // Memory word for the presented address
    logic        irq_pending;
    regbank_wb_t wb;
    mem_write_t  mem_wr;
    redirect_t   redirect;
    trap_t       trap;
    logic        killed;
    tag_t        tag_out;

    tag_t model_tag;            // Tracked from expected effects only
    int   cycle_count = 0;
    int   err_wb      = 0;
    int   err_mem     = 0;
    int   err_redirect = 0;
    int   err_trap    = 0;
    int   err_killed  = 0;
    int   err_tag     = 0;

    `include "retire_model.svh"

    retire_top #(
        .TAG_WIDTH (TAG_WIDTH)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .ret_i         (ret_in),
        .tag_i         (tag_in),
        .mem_data_i    (mem_data),
        .irq_pending_i (irq_pending),
        .wb_o          (wb),
        .mem_o         (mem_wr),
        .redirect_o    (redirect),
        .trap_o        (trap),
        .killed_o      (killed),
        .tag_o         (tag_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic writeback_check(input regbank_wb_t got, input regbank_wb_t want);
        // Data is a don't care while the write is off
        if (got.enable !== want.enable || (want.enable && got.data !== want.data)) begin
            $display("[FAIL] %0t: writeback en=%b data=%h, expected en=%b data=%h",
                     $time, got.enable, got.data, want.enable, want.data);
            err_wb++;
        end
    endtask

    task automatic store_check(input mem_write_t got, input mem_write_t want);
        if (got !== want) begin
            $display("[FAIL] %0t: store be=%b addr=%h data=%h, expected be=%b addr=%h data=%h",
                     $time, got.byte_enable, got.address, got.data,
                     want.byte_enable, want.address, want.data);
            err_mem++;
        end
    endtask

    task automatic redirect_check(input redirect_t got, input redirect_t want);
        if (got.jump !== want.jump || (want.jump && got.target !== want.target)) begin
            $display("[FAIL] %0t: redirect jump=%b target=%h, expected jump=%b target=%h",
                     $time, got.jump, got.target, want.jump, want.target);
            err_redirect++;
        end
    endtask

    task automatic trap_check(input trap_t got, input trap_t want);
        if (got !== want) begin
            $display("[FAIL] %0t: trap exc=%b code=%0d mret=%b ack=%b, expected %b %0d %b %b",
                     $time, got.raise_exception, got.code, got.machine_return,
                     got.interrupt_ack, want.raise_exception, want.code,
                     want.machine_return, want.interrupt_ack);
            err_trap++;
        end
    endtask

    task automatic kill_check(input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] %0t: killed=%b, expected %b", $time, got, want);
            err_killed++;
        end
    endtask

    task automatic tag_check(input tag_t got, input tag_t want);
        if (got !== want) begin
            $display("[FAIL] %0t: tag=%0d, expected %0d", $time, got, want);
            err_tag++;
        end
    endtask

    // Every output against an idle expectation, used around the random run
    task automatic idle_check();
        writeback_check(wb, wb_expect(ret_in, 1'b0, mem_data));
        store_check(mem_wr, store_expect(ret_in, 1'b0));
        redirect_check(redirect, redirect_expect(ret_in, 1'b0));
        trap_check(trap, trap_expect(ret_in, 1'b0, irq_pending));
        kill_check(killed, 1'b0);
        tag_check(tag_out, model_tag);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Timeout
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        retire_in_t  instr;
        logic        live;
        redirect_t   want_redirect;
        trap_t       want_trap;

        reset       = 1'b1;
        ret_in      = '0;
        tag_in      = '0;
        mem_data    = '0;
        irq_pending = 1'b0;
        model_tag   = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1 idle_check();                      // Tag zero and all quiet out of reset

        for (int i = 0; i < NUM_INSTR; i++) begin
            @(negedge clk);
            tag_check(tag_out, model_tag);    // Step from the previous rising edge
            instr       = random_instr();
            mem_data    = lcg_next();
            irq_pending = rand_below(8) == 0;
            // Three in four on the current path, the rest on any stale tag
            if (rand_below(4) != 0) tag_in = model_tag;
            else tag_in = model_tag + tag_t'(1 + rand_below(2 ** TAG_WIDTH - 1));
            ret_in = instr;
            #1;
            live          = instr.valid && (tag_in == model_tag);
            want_redirect = redirect_expect(instr, live);
            want_trap     = trap_expect(instr, live, irq_pending);
            writeback_check(wb, wb_expect(instr, live, mem_data));
            store_check(mem_wr, store_expect(instr, live));
            redirect_check(redirect, want_redirect);
            trap_check(trap, want_trap);
            kill_check(killed, instr.valid && !live);
            if (want_redirect.jump || want_trap.raise_exception
                || want_trap.machine_return || want_trap.interrupt_ack) begin
                model_tag = model_tag + 1'b1;  // Wraps with the tag width
            end
        end

        @(negedge clk);
        ret_in      = '0;
        irq_pending = 1'b0;
        #1 idle_check();

        $display("Errors: wb %0d, mem %0d, redirect %0d, trap %0d, killed %0d, tag %0d",
                 err_wb, err_mem, err_redirect, err_trap, err_killed, err_tag);
        if (err_wb + err_mem + err_redirect + err_trap + err_killed + err_tag == 0) begin
            $display("Regression passed");
        end
        else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb.f */
design/retire_isa_pkg.sv
design/retire_bus_pkg.sv
design/load_align.sv
design/trap_decode.sv
design/retire_ctrl.sv
design/retire_top.sv
+incdir+testbench
testbench/retire_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the retire stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    -f tb.f \
    --top-module retire_tb \
    -o retire_sim

./obj_dir/retire_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
